// File: hdl/fb_defines.svh
`ifndef FB_DEFINES_SVH
`define FB_DEFINES_SVH

// Visible area in pixels and lines, kept tiny so a frame simulates quickly
`define FB_H_ACTIVE 16
`define FB_V_ACTIVE 4

// Blanking in clocks per line and in whole lines per frame
`define FB_H_BLANK 8
`define FB_V_BLANK 2

// Hsync occupies the start of horizontal blanking
`define FB_HSYNC_LEN 4

// Beats per AXI read burst, the frame must be a whole number of bursts
`define FB_BURST_LEN 8

`define FB_FIFO_DEPTH 32

// Byte base addresses of the two framebuffers
`define FB_1_ADDR 32'h01E00000
`define FB_2_ADDR 32'h01C00000

`endif

// File: hdl/fb_pkg.sv
`include "fb_defines.svh"

package fb_pkg;

    // Byte address on the memory bus
    typedef logic [31:0] addr_t;

    // Red in the upper byte, blue in the lower byte
    typedef logic [23:0] pixel_t;

    // AXI burst length field, beats minus one
    typedef logic [7:0] axi_len_t;

    typedef logic [3:0] axi_id_t;

    // Wide enough to hold a completely empty FIFO's free count
    typedef logic [$clog2(`FB_FIFO_DEPTH + 1) - 1:0] fifo_level_t;

endpackage

// File: hdl/fb_swap_ctrl.sv
`timescale 1ns/1ps
`include "fb_defines.svh"

module fb_swap_ctrl
(
    input  logic          aclkLogic,
    input  logic          resetn,
    input  logic          swap_i,
    input  logic          frame_start_i,
    output logic          swapped_o,
    output fb_pkg::addr_t display_base_o
);
    fb_pkg::addr_t pending_q;

    // Swap handshake, the rasterizer holds swap_i until swapped_o drops
    always_ff @(posedge aclkLogic)
    begin
        if (!resetn)
        begin
            pending_q <= `FB_2_ADDR;
            swapped_o <= 1'b1;
        end
        else
        begin
            if (swap_i && swapped_o)
            begin
                if (pending_q == `FB_1_ADDR)
                begin
                    pending_q <= `FB_2_ADDR;
                end
                else
                begin
                    pending_q <= `FB_1_ADDR;
                end
                swapped_o <= 1'b0;
            end
            if (!swap_i)
            begin
                swapped_o <= 1'b1;
            end
        end
    end

    // The displayed buffer only changes between frames so nothing tears
    always_ff @(posedge aclkLogic)
    begin
        if (!resetn)
        begin
            display_base_o <= `FB_1_ADDR;
        end
        else if (frame_start_i)
        begin
            display_base_o <= pending_q;
        end
    end

    a_base_valid: assert property (@(posedge aclkLogic) disable iff (!resetn)
        (display_base_o == `FB_1_ADDR) || (display_base_o == `FB_2_ADDR));

endmodule

// File: hdl/pixel_fifo.sv
`timescale 1ns/1ps
`include "fb_defines.svh"

module pixel_fifo
(
    input  logic                aclkLogic,
    input  logic                resetn,
    input  logic                flush_i,
    input  logic                push_i,
    input  fb_pkg::pixel_t      push_data_i,
    input  logic                pop_i,
    output fb_pkg::pixel_t      pop_data_o,
    output logic                empty_o,
    output fb_pkg::fifo_level_t free_o
);
    localparam int PW = $clog2(`FB_FIFO_DEPTH);
    localparam fb_pkg::fifo_level_t DEPTH = fb_pkg::fifo_level_t'(`FB_FIFO_DEPTH);

    fb_pkg::pixel_t      mem [`FB_FIFO_DEPTH];
    logic [PW-1:0]       wr_ptr_q;
    logic [PW-1:0]       rd_ptr_q;
    fb_pkg::fifo_level_t count_q;

    always_ff @(posedge aclkLogic)
    begin
        if (push_i)
        begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end

    always_ff @(posedge aclkLogic)
    begin
        if (!resetn || flush_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            // Depth is a power of two, so the pointers wrap by themselves
            if (push_i)
            begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_i)
            begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (push_i && !pop_i)
            begin
                count_q <= count_q + 1'b1;
            end
            else if (pop_i && !push_i)
            begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Head entry is visible before the pop that consumes it
    assign pop_data_o = mem[rd_ptr_q];
    assign empty_o    = (count_q == '0);
    assign free_o     = DEPTH - count_q;

    a_no_overflow: assert property (@(posedge aclkLogic) disable iff (!resetn)
        push_i && !flush_i |-> count_q != DEPTH);

    a_no_underflow: assert property (@(posedge aclkLogic) disable iff (!resetn)
        pop_i |-> !empty_o);

endmodule

// File: hdl/fb_scanout_dma.sv
`timescale 1ns/1ps
`include "fb_defines.svh"

module fb_scanout_dma
(
    input  logic                aclkLogic,
    input  logic                resetn,
    input  logic                frame_start_i,
    input  fb_pkg::addr_t       display_base_i,
    input  fb_pkg::fifo_level_t fifo_free_i,
    output logic                fifo_flush_o,
    output logic                fifo_push_o,
    output fb_pkg::pixel_t      fifo_data_o,
    output logic                m_axi_arvalid_o,
    input  logic                m_axi_arready_i,
    output fb_pkg::addr_t       m_axi_araddr_o,
    output fb_pkg::axi_len_t    m_axi_arlen_o,
    input  logic                m_axi_rvalid_i,
    input  logic [31:0]         m_axi_rdata_i,
    input  logic                m_axi_rlast_i,
    output logic                m_axi_rready_o
);
    localparam int NUM_BURSTS = (`FB_H_ACTIVE * `FB_V_ACTIVE) / `FB_BURST_LEN;
    localparam int BW = $clog2(NUM_BURSTS + 1);
    localparam int CW = $clog2(`FB_BURST_LEN);
    localparam fb_pkg::addr_t BURST_BYTES = fb_pkg::addr_t'(4 * `FB_BURST_LEN);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA,
        ST_WAIT_SPACE
    } state_t;

    state_t        state_q;
    fb_pkg::addr_t addr_q;
    logic [BW-1:0] bursts_left_q;
    logic [CW-1:0] beat_cnt_q;
    logic          pending_q;
    logic          flush_q;
    logic          start;
    logic          beat;
    logic          last_beat;

    // A new frame may only begin between bursts, never with a burst in flight
    assign start     = pending_q && (state_q == ST_IDLE || state_q == ST_WAIT_SPACE);
    assign beat      = m_axi_rvalid_i && m_axi_rready_o;
    assign last_beat = (beat_cnt_q == CW'(`FB_BURST_LEN - 1));

    always_ff @(posedge aclkLogic)
    begin
        if (!resetn)
        begin
            state_q       <= ST_IDLE;
            pending_q     <= 1'b0;
            flush_q       <= 1'b0;
            bursts_left_q <= '0;
            beat_cnt_q    <= '0;
        end
        else
        begin
            flush_q   <= start;
            pending_q <= (pending_q && !start) || frame_start_i;
            if (start)
            begin
                state_q       <= ST_WAIT_SPACE;
                bursts_left_q <= BW'(NUM_BURSTS);
            end
            else
            begin
                case (state_q)
                    ST_WAIT_SPACE:
                    begin
                        // Free count is stale while the flush is in progress
                        if (bursts_left_q == '0)
                        begin
                            state_q <= ST_IDLE;
                        end
                        else if (!flush_q &&
                                 fifo_free_i >= fb_pkg::fifo_level_t'(`FB_BURST_LEN))
                        begin
                            state_q <= ST_ADDR;
                        end
                    end
                    ST_ADDR:
                    begin
                        if (m_axi_arready_i)
                        begin
                            state_q    <= ST_DATA;
                            beat_cnt_q <= '0;
                        end
                    end
                    ST_DATA:
                    begin
                        if (beat)
                        begin
                            beat_cnt_q <= beat_cnt_q + 1'b1;
                            if (last_beat)
                            begin
                                bursts_left_q <= bursts_left_q - 1'b1;
                                state_q       <= ST_WAIT_SPACE;
                            end
                        end
                    end
                    default:
                    begin
                        state_q <= ST_IDLE;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge aclkLogic)
    begin
        if (start)
        begin
            addr_q <= display_base_i;
        end
        else if (beat && last_beat)
        begin
            addr_q <= addr_q + BURST_BYTES;
        end
    end

    assign m_axi_arvalid_o = (state_q == ST_ADDR);
    assign m_axi_araddr_o  = addr_q;
    assign m_axi_arlen_o   = fb_pkg::axi_len_t'(`FB_BURST_LEN - 1);
    assign m_axi_rready_o  = (state_q == ST_DATA) && (fifo_free_i != '0);

    assign fifo_flush_o = flush_q;
    assign fifo_push_o  = beat;
    assign fifo_data_o  = m_axi_rdata_i[23:0];

    a_rlast_on_count: assert property (@(posedge aclkLogic) disable iff (!resetn)
        beat |-> (m_axi_rlast_i == last_beat));

endmodule

// File: hdl/video_timing.sv
`timescale 1ns/1ps
`include "fb_defines.svh"

module video_timing
(
    input  logic aclkLogic,
    input  logic resetn,
    output logic de_o,
    output logic hsync_o,
    output logic vsync_o,
    output logic frame_start_o
);
    localparam int H_TOTAL = `FB_H_ACTIVE + `FB_H_BLANK;
    localparam int V_TOTAL = `FB_V_ACTIVE + `FB_V_BLANK;
    localparam int HW = $clog2(H_TOTAL);
    localparam int VW = $clog2(V_TOTAL);

    localparam logic [HW-1:0] H_LAST      = HW'(H_TOTAL - 1);
    localparam logic [VW-1:0] V_LAST      = VW'(V_TOTAL - 1);
    localparam logic [HW-1:0] H_ACT       = HW'(`FB_H_ACTIVE);
    localparam logic [HW-1:0] H_SYNC_END  = HW'(`FB_H_ACTIVE + `FB_HSYNC_LEN);
    localparam logic [VW-1:0] V_ACT       = VW'(`FB_V_ACTIVE);

    logic [HW-1:0] h_q;
    logic [VW-1:0] v_q;

    // Position counters, column runs fastest
    always_ff @(posedge aclkLogic)
    begin
        if (!resetn)
        begin
            h_q <= '0;
            v_q <= '0;
        end
        else if (h_q == H_LAST)
        begin
            h_q <= '0;
            if (v_q == V_LAST)
            begin
                v_q <= '0;
            end
            else
            begin
                v_q <= v_q + 1'b1;
            end
        end
        else
        begin
            h_q <= h_q + 1'b1;
        end
    end

    // Outputs lag the counters by one clock, so position 0,0 appears right after reset
    always_ff @(posedge aclkLogic)
    begin
        if (!resetn)
        begin
            de_o          <= 1'b0;
            hsync_o       <= 1'b0;
            vsync_o       <= 1'b0;
            frame_start_o <= 1'b0;
        end
        else
        begin
            de_o          <= (h_q < H_ACT) && (v_q < V_ACT);
            hsync_o       <= (h_q >= H_ACT) && (h_q < H_SYNC_END);
            vsync_o       <= (v_q == V_ACT);
            frame_start_o <= (v_q == V_ACT) && (h_q == '0);
        end
    end

endmodule

// File: hdl/fb_display.sv
`timescale 1ns/1ps

module fb_display
(
    input  logic             aclkLogic,
    input  logic             resetn,
    input  logic             swap_i,
    output logic             swapped_o,
    output logic             m_axi_arvalid_o,
    input  logic             m_axi_arready_i,
    output fb_pkg::addr_t    m_axi_araddr_o,
    output fb_pkg::axi_len_t m_axi_arlen_o,
    output fb_pkg::axi_id_t  m_axi_arid_o,
    output logic [2:0]       m_axi_arsize_o,
    output logic [1:0]       m_axi_arburst_o,
    output logic             m_axi_arlock_o,
    output logic [3:0]       m_axi_arcache_o,
    output logic [2:0]       m_axi_arprot_o,
    input  logic             m_axi_rvalid_i,
    input  logic [31:0]      m_axi_rdata_i,
    input  logic             m_axi_rlast_i,
    input  logic [1:0]       m_axi_rresp_i,
    output logic             m_axi_rready_o,
    output fb_pkg::pixel_t   pixel_o,
    output logic             de_o,
    output logic             hsync_o,
    output logic             vsync_o,
    output logic             underrun_o
);
    logic                frame_start;
    fb_pkg::addr_t       display_base;
    fb_pkg::fifo_level_t fifo_free;
    logic                fifo_flush;
    logic                fifo_push;
    fb_pkg::pixel_t      fifo_push_data;
    fb_pkg::pixel_t      fifo_head;
    logic                fifo_empty;
    logic                fifo_pop;

    // Word reads with incrementing bursts, everything else left at zero
    assign m_axi_arid_o    = '0;
    assign m_axi_arsize_o  = 3'd2;
    assign m_axi_arburst_o = 2'b01;
    assign m_axi_arlock_o  = 1'b0;
    assign m_axi_arcache_o = 4'd0;
    assign m_axi_arprot_o  = 3'd0;

    fb_swap_ctrl u_swap (
        .aclkLogic      (aclkLogic),
        .resetn         (resetn),
        .swap_i         (swap_i),
        .frame_start_i  (frame_start),
        .swapped_o      (swapped_o),
        .display_base_o (display_base)
    );

    fb_scanout_dma u_dma (
        .aclkLogic       (aclkLogic),
        .resetn          (resetn),
        .frame_start_i   (frame_start),
        .display_base_i  (display_base),
        .fifo_free_i     (fifo_free),
        .fifo_flush_o    (fifo_flush),
        .fifo_push_o     (fifo_push),
        .fifo_data_o     (fifo_push_data),
        .m_axi_arvalid_o (m_axi_arvalid_o),
        .m_axi_arready_i (m_axi_arready_i),
        .m_axi_araddr_o  (m_axi_araddr_o),
        .m_axi_arlen_o   (m_axi_arlen_o),
        .m_axi_rvalid_i  (m_axi_rvalid_i),
        .m_axi_rdata_i   (m_axi_rdata_i),
        .m_axi_rlast_i   (m_axi_rlast_i),
        .m_axi_rready_o  (m_axi_rready_o)
    );

    pixel_fifo u_fifo (
        .aclkLogic   (aclkLogic),
        .resetn      (resetn),
        .flush_i     (fifo_flush),
        .push_i      (fifo_push),
        .push_data_i (fifo_push_data),
        .pop_i       (fifo_pop),
        .pop_data_o  (fifo_head),
        .empty_o     (fifo_empty),
        .free_o      (fifo_free)
    );

    video_timing u_timing (
        .aclkLogic     (aclkLogic),
        .resetn        (resetn),
        .de_o          (de_o),
        .hsync_o       (hsync_o),
        .vsync_o       (vsync_o),
        .frame_start_o (frame_start)
    );

    // Video never waits, a missing pixel shows as black
    assign fifo_pop = de_o && !fifo_empty;
    assign pixel_o  = fifo_pop ? fifo_head : '0;

    // Sticky until reset so software can see that any pixel was lost
    always_ff @(posedge aclkLogic)
    begin
        if (!resetn)
        begin
            underrun_o <= 1'b0;
        end
        else if (de_o && fifo_empty)
        begin
            underrun_o <= 1'b1;
        end
    end

    a_read_okay: assert property (@(posedge aclkLogic) disable iff (!resetn)
        m_axi_rvalid_i && m_axi_rready_o |-> m_axi_rresp_i == 2'b00);

endmodule

// File: testbench/tb_fb_display.sv
`timescale 1ns/1ps
`include "fb_defines.svh"

module tb_fb_display;
    localparam int H_TOTAL = `FB_H_ACTIVE + `FB_H_BLANK;
    localparam int FRAME   = H_TOTAL * (`FB_V_ACTIVE + `FB_V_BLANK);
    localparam int FS_POS  = `FB_V_ACTIVE * H_TOTAL;
    localparam int BURSTS  = (`FB_H_ACTIVE * `FB_V_ACTIVE) / `FB_BURST_LEN;

    logic aclkLogic, resetn, swap_i, swapped_o;
    logic m_axi_arvalid_o, m_axi_arready_i, m_axi_rvalid_i, m_axi_rlast_i, m_axi_rready_o;
    fb_pkg::addr_t m_axi_araddr_o;
    fb_pkg::axi_len_t m_axi_arlen_o;
    fb_pkg::axi_id_t m_axi_arid_o;
    logic [2:0] m_axi_arsize_o, m_axi_arprot_o;
    logic [1:0] m_axi_arburst_o, m_axi_rresp_i;
    logic m_axi_arlock_o;
    logic [3:0] m_axi_arcache_o;
    logic [31:0] m_axi_rdata_i;
    fb_pkg::pixel_t pixel_o;
    logic de_o, hsync_o, vsync_o, underrun_o;

    string cur_name;
    int cur_lat, cur_under, errors, checks, run_cycles, cycle_limit, num_cases, i;
    string case_name [16];
    int case_swap [16], case_hold [16], case_swap2 [16], case_lat [16];
    int case_frames [16], case_under [16];
    // Reference model and monitor state, updated once per clock at the falling edge
    int cyc, p, col, ln, frame, seq_idx, drops, ar_left, beats_left, ar_wait;
    logic m_swapped, swap_last, restart_pending, exp_de;
    fb_pkg::addr_t m_pending, m_base, ar_next, exp_addr, burst_addr, ar_addr_seen;
    logic mem_reset, ar_seen, ar_fire, r_fire;
    logic [31:0] lcg_state, rnd;

    fb_display dut (.*);

    initial
    begin
        aclkLogic = 1'b0;
        forever #20 aclkLogic = ~aclkLogic;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic note_failure(input string msg);
        errors++;
        $display("%s: %s", cur_name, msg);
    endtask

    task automatic check_pixel(input string what, input fb_pkg::pixel_t exp,
                               input fb_pkg::pixel_t act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("[ERROR] %s %s: expected %h actual %h", cur_name, what, exp, act);
        end
    endtask

    task automatic check_addr(input string what, input fb_pkg::addr_t exp,
                              input fb_pkg::addr_t act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("[ERROR] %s %s: expected %h actual %h", cur_name, what, exp, act);
        end
    endtask

    task automatic check_len(input string what, input fb_pkg::axi_len_t exp,
                             input fb_pkg::axi_len_t act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("[ERROR] %s %s: expected %0d actual %0d", cur_name, what, exp, act);
        end
    endtask

    // Fixed AR attribute fields, all four bits wide or narrower
    task automatic check_attr(input string what, input logic [3:0] exp,
                              input logic [3:0] act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("[ERROR] %s %s: expected %h actual %h", cur_name, what, exp, act);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("[ERROR] %s %s at cycle %0d: expected %b actual %b",
                     cur_name, what, cyc, exp, act);
        end
    endtask

    task automatic next_cycles(input int n);
        repeat (n) @(posedge aclkLogic);
        #2;
    endtask

    // Memory model, responds to what the falling edge saw transfer at this rising edge
    always @(posedge aclkLogic)
    begin
        #2;
        if (mem_reset)
        begin
            m_axi_arready_i = 1'b0;
            m_axi_rvalid_i  = 1'b0;
            m_axi_rlast_i   = 1'b0;
            beats_left = 0;
            ar_wait = 0;
        end
        else
        begin
            if (ar_fire)
            begin
                m_axi_arready_i = 1'b0;
                ar_wait = 0;
                burst_addr = ar_addr_seen;
                beats_left = `FB_BURST_LEN;
            end
            else if (ar_seen)
            begin
                ar_wait++;
                m_axi_arready_i = (ar_wait >= cur_lat);
            end
            if (r_fire)
            begin
                burst_addr = burst_addr + 32'd4;
                beats_left--;
            end
            // A beat once offered stays valid until it is taken
            if (r_fire || !m_axi_rvalid_i)
            begin
                rnd = lcg_next();
                m_axi_rvalid_i = (beats_left != 0) && (rnd[31:29] != 3'd0);
            end
            m_axi_rdata_i = burst_addr;
            m_axi_rlast_i = (beats_left == 1);
        end
    end

    always @(negedge aclkLogic)
    begin
        if (!resetn)
        begin
            cyc = 0;
            m_swapped = 1'b1;
            m_pending = `FB_2_ADDR;
            m_base = `FB_1_ADDR;
            swap_last = swap_i;
            restart_pending = 1'b0;
            ar_left = 0;
            seq_idx = 0;
            drops = 0;
            mem_reset = 1'b1;
            ar_seen = 1'b0;
            ar_fire = 1'b0;
            r_fire = 1'b0;
        end
        else
        begin
            cyc++;
            mem_reset = 1'b0;
            // The edge just passed saw the frame start pulse of the cycle before it
            if (cyc >= 3 && (cyc - 3) % FRAME == FS_POS)
            begin
                m_base = m_pending;
                restart_pending = 1'b1;
            end
            if (swap_last && m_swapped)
            begin
                m_pending = (m_pending == `FB_1_ADDR) ? `FB_2_ADDR : `FB_1_ADDR;
                m_swapped = 1'b0;
            end
            else if (!swap_last)
            begin
                m_swapped = 1'b1;
            end
            swap_last = swap_i;
            check_flag("swapped_o", m_swapped, swapped_o);

            // The first clock after reset still shows the idle outputs
            p = (cyc + FRAME - 2) % FRAME;
            frame = (cyc + FRAME - 2) / FRAME - 1;
            col = p % H_TOTAL;
            ln = p / H_TOTAL;
            exp_de = (col < `FB_H_ACTIVE) && (ln < `FB_V_ACTIVE);
            check_flag("de_o", exp_de, de_o);
            check_flag("hsync_o", col >= `FB_H_ACTIVE && col < `FB_H_ACTIVE + `FB_HSYNC_LEN,
                       hsync_o);
            check_flag("vsync_o", ln == `FB_V_ACTIVE, vsync_o);
            // Nothing is fetched before the first line, so its first pixel is lost
            check_flag("underrun_o", cyc >= 3, underrun_o);

            // Pixels leave the FIFO in address order, a lost one only shows as black
            if (p == 0)
            begin
                seq_idx = 0;
            end
            if (frame >= 1 && exp_de)
            begin
                if (cur_under != 0 && pixel_o == '0)
                begin
                    drops++;
                end
                else
                begin
                    exp_addr = m_base + 32'(4 * seq_idx);
                    check_pixel($sformatf("pixel frame %0d line %0d col %0d", frame, ln, col),
                                exp_addr[23:0], pixel_o);
                    seq_idx++;
                end
            end

            if (m_axi_arvalid_o && m_axi_arready_i)
            begin
                check_len("arlen", fb_pkg::axi_len_t'(`FB_BURST_LEN - 1), m_axi_arlen_o);
                check_attr("arid", 4'd0, 4'(m_axi_arid_o));
                check_attr("arsize", 4'd2, 4'(m_axi_arsize_o));
                check_attr("arburst", 4'd1, 4'(m_axi_arburst_o));
                check_attr("arcache", 4'd0, m_axi_arcache_o);
                check_attr("arprot", 4'd0, 4'(m_axi_arprot_o));
                check_flag("arlock", 1'b0, m_axi_arlock_o);
                if (restart_pending && m_axi_araddr_o == m_base)
                begin
                    restart_pending = 1'b0;
                    ar_next = m_base + 32'(4 * `FB_BURST_LEN);
                    ar_left = BURSTS - 1;
                end
                else if (ar_left == 0)
                begin
                    note_failure($sformatf("read burst at %h beyond the frame", m_axi_araddr_o));
                end
                else
                begin
                    check_addr("araddr", ar_next, m_axi_araddr_o);
                    ar_next = ar_next + 32'(4 * `FB_BURST_LEN);
                    ar_left--;
                end
            end
            ar_seen = m_axi_arvalid_o && !m_axi_arready_i;
            ar_fire = m_axi_arvalid_o && m_axi_arready_i;
            ar_addr_seen = m_axi_araddr_o;
            r_fire = m_axi_rvalid_i && m_axi_rready_o;
        end
    end

    always @(posedge aclkLogic)
    begin
        run_cycles++;
        if (cycle_limit > 0 && run_cycles > cycle_limit)
        begin
            $display("Timeout after %0d cycles in case %s", run_cycles, cur_name);
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic load_cases();
        int fd, n, sw, hold, sw2, lat, frames, under;
        string line, nm;
        fd = $fopen("testbench/fb_cases.txt", "r");
        if (fd == 0)
        begin
            note_failure("cannot open testbench/fb_cases.txt");
        end
        while (fd != 0 && !$feof(fd) && num_cases < 16)
        begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() > 1 && line.getc(0) != "#")
            begin
                n = $sscanf(line, "%s %d %d %d %d %d %d", nm, sw, hold, sw2, lat, frames, under);
                if (n == 7)
                begin
                    case_name[num_cases] = nm;
                    case_swap[num_cases] = sw;
                    case_hold[num_cases] = hold;
                    case_swap2[num_cases] = sw2;
                    case_lat[num_cases] = lat;
                    case_frames[num_cases] = frames;
                    case_under[num_cases] = under;
                    cycle_limit += frames * FRAME * 2 + 16;
                    num_cases++;
                end
            end
        end
        if (fd != 0)
        begin
            $fclose(fd);
        end
    endtask

    task automatic run_case(input int idx);
        int t, err_start, on1, off1, on2, off2;
        cur_name = case_name[idx];
        cur_lat = case_lat[idx];
        cur_under = case_under[idx];
        err_start = errors;
        resetn = 1'b0;
        swap_i = 1'b0;
        next_cycles(16);
        resetn = 1'b1;
        on1 = case_swap[idx] * FRAME + 10;
        off1 = on1 + case_hold[idx] * FRAME;
        on2 = case_swap2[idx] * FRAME + 10;
        off2 = on2 + FRAME;
        for (t = 1; t <= case_frames[idx] * FRAME; t++)
        begin
            next_cycles(1);
            if ((case_swap[idx] > 0 && t == on1) || (case_swap2[idx] > 0 && t == on2))
            begin
                swap_i = 1'b1;
            end
            if ((case_swap[idx] > 0 && t == off1) || (case_swap2[idx] > 0 && t == off2))
            begin
                swap_i = 1'b0;
            end
        end
        if (cur_under != 0)
        begin
            if (drops == 0)
            begin
                note_failure("slow memory produced no black pixels");
            end
        end
        $display("Case %s finished after %0d frames with %0d errors",
                 cur_name, case_frames[idx], errors - err_start);
    endtask

    initial
    begin
        resetn = 1'b0;
        swap_i = 1'b0;
        m_axi_arready_i = 1'b0;
        m_axi_rvalid_i = 1'b0;
        m_axi_rdata_i = '0;
        m_axi_rlast_i = 1'b0;
        m_axi_rresp_i = 2'b00;
        lcg_state = 32'h47d9_4f2e;
        cur_name = "setup";
        cur_lat = 0;
        cur_under = 0;
        errors = 0;
        checks = 0;
        run_cycles = 0;
        cycle_limit = 0;
        num_cases = 0;
        load_cases();
        if (num_cases == 0)
        begin
            note_failure("no cases were read");
        end
        cycle_limit += 200;
        for (i = 0; i < num_cases; i++)
        begin
            run_case(i);
        end
        $display("Cases %0d, checks %0d, errors %0d", num_cases, checks, errors);
        if (errors == 0)
        begin
            $display("*** PASSED ***");
        end
        else
        begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+hdl
hdl/fb_pkg.sv
hdl/fb_swap_ctrl.sv
hdl/pixel_fifo.sv
hdl/fb_scanout_dma.sv
hdl/video_timing.sv
hdl/fb_display.sv
testbench/tb_fb_display.sv

// File: Makefile
.PHONY: all sim lint clean

all: sim

obj_dir/Vtb_fb_display: build.f hdl/*.sv hdl/*.svh testbench/*.sv
	verilator --binary --timing --assert -f build.f --top-module tb_fb_display

sim: obj_dir/Vtb_fb_display
	./obj_dir/Vtb_fb_display | tee sim.log
	grep -q -F "*** PASSED ***" sim.log

lint:
	verilator --lint-only --timing -f build.f --top-module tb_fb_display

clean:
	rm -rf obj_dir sim.log

// File: testbench/fb_cases.txt
# name swap_frame hold_frames swap2_frame latency frames underrun
# Swap frames of 0 mean no swap, a second swap is held one frame, underrun 1 expects black pixels
reset_only 0 0 0 1 4 0
single_swap 2 1 0 2 6 0
held_swap 1 3 6 2 9 0
stall_latency 2 1 4 3 7 0
slow_memory 0 0 0 24 5 1
